//--- hdl/diad_pkg.sv
package diad_pkg;

    localparam int DATA_W        = 16;
    localparam int REG_N         = 8;
    localparam int REG_W         = 3;
    localparam int IMEM_N        = 32;
    localparam int IADDR_W       = 5;
    localparam int DMEM_N        = 16;
    localparam int DADDR_W       = 4;
    localparam int IMM_W         = 6;
    localparam int TRACE_CREDITS = 4;
    localparam int CREDIT_W      = 3;  // Holds 0 to TRACE_CREDITS.
    localparam int PEND_W        = 2;  // Up to three writers in de, em and mw.

    typedef enum logic [3:0] {
        OP_HALT = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LD   = 4'd7,
        OP_ST   = 4'd8
    } opcode_t;

    typedef struct packed {
        opcode_t          opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [2:0]       unused;
    } instr_r_t;

    typedef struct packed {
        opcode_t                 opcode;
        logic [REG_W-1:0]        rd;
        logic [REG_W-1:0]        rs1;
        logic signed [IMM_W-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    function automatic logic writes_rd(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD};
    endfunction

    function automatic logic reads_rs1(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD, OP_ST};
    endfunction

    function automatic logic reads_rs2(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    endfunction

    function automatic logic uses_imm(opcode_t op);
        return op inside {OP_ADDI, OP_LD, OP_ST};
    endfunction

    function automatic logic [DATA_W-1:0] sext_imm(logic signed [IMM_W-1:0] imm);
        return {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

endpackage

//--- hdl/pipe_link_if.sv
`timescale 1ns/1ns

interface pipe_link_if;
    import diad_pkg::*;

    logic               valid;
    logic [IADDR_W-1:0] pc;
    instr_t             instr;
    logic [DATA_W-1:0]  op_a;
    logic [DATA_W-1:0]  op_b;
    logic [DATA_W-1:0]  result;  // ALU value, data address or loaded word.

    modport producer (
        output valid, pc, instr, op_a, op_b, result
    );

    modport consumer (
        input valid, pc, instr, op_a, op_b, result
    );

endinterface

//--- hdl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
    input logic                          iw_clk,
    input logic                          iw_rst,
    input logic                          run,
    input logic                          load_en,
    input logic [diad_pkg::IADDR_W-1:0]  load_addr,
    input diad_pkg::instr_t              load_data,
    input logic                          freeze,
    input logic                          hold_fetch,
    pipe_link_if.producer                fd
);
    import diad_pkg::*;

    instr_t             imem [IMEM_N];
    logic [IADDR_W-1:0] pc;
    logic               stopped;
    logic               advance;

    assign advance = !freeze && !hold_fetch;

    always_ff @(posedge iw_clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc       <= '0;
            stopped  <= 1'b0;
            fd.valid <= 1'b0;
        end else if (advance) begin
            if (run && !stopped) begin
                fd.valid <= 1'b1;
                pc       <= pc + IADDR_W'(1);
                if (imem[pc].r.opcode == OP_HALT) begin
                    stopped <= 1'b1;  // Nothing past HALT is fetched.
                end
            end else begin
                fd.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        if (advance) begin
            fd.pc    <= pc;
            fd.instr <= imem[pc];
        end
    end

    // Operands are filled in by decode.
    assign fd.op_a   = '0;
    assign fd.op_b   = '0;
    assign fd.result = '0;

    a_no_load_while_run: assert property (
        @(posedge iw_clk) disable iff (iw_rst) !(load_en && run)
    ) else $error("fetch_stage: instruction memory loaded while running");

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input logic                         iw_clk,
    input logic                         iw_rst,
    input logic                         freeze,
    pipe_link_if.consumer               fd,
    pipe_link_if.producer               de,
    input logic                         wb_we,
    input logic [diad_pkg::REG_W-1:0]   wb_rd,
    input logic [diad_pkg::DATA_W-1:0]  wb_data,
    output logic                        hold_fetch
);
    import diad_pkg::*;

    logic [DATA_W-1:0] regs [REG_N];
    logic [PEND_W-1:0] pend [REG_N];
    logic [REG_N-1:0]  pend_inc;
    logic [REG_N-1:0]  pend_dec;
    instr_t            ins;
    opcode_t           op;
    logic              hazard;
    logic              issue;

    assign ins = fd.instr;
    assign op  = ins.r.opcode;

    // ST reads rd as its store data.
    assign hazard = fd.valid && (
        (reads_rs1(op) && pend[ins.r.rs1] != '0) ||
        (reads_rs2(op) && pend[ins.r.rs2] != '0) ||
        (op == OP_ST && pend[ins.r.rd] != '0));

    assign hold_fetch = hazard;
    assign issue      = fd.valid && !hazard && !freeze;

    assign pend_inc = (issue && writes_rd(op)) ? (REG_N'(1) << ins.r.rd) : '0;
    assign pend_dec = wb_we ? (REG_N'(1) << wb_rd) : '0;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < REG_N; i++) begin
                pend[i] <= '0;
            end
        end else begin
            for (int i = 0; i < REG_N; i++) begin
                case ({pend_inc[i], pend_dec[i]})
                    2'b10:   pend[i] <= pend[i] + PEND_W'(1);
                    2'b01:   pend[i] <= pend[i] - PEND_W'(1);
                    default: pend[i] <= pend[i];  // Issue and retire cancel out.
                endcase
            end
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            de.valid <= 1'b0;
        end else if (!freeze) begin
            de.valid <= fd.valid && !hazard;  // Bubble while stalled.
        end
    end

    always_ff @(posedge iw_clk) begin
        if (!freeze) begin
            de.pc     <= fd.pc;
            de.instr  <= ins;
            de.op_a   <= regs[ins.r.rs1];
            de.op_b   <= uses_imm(op) ? sext_imm(ins.i.imm) : regs[ins.r.rs2];
            de.result <= regs[ins.r.rd];  // Store data.
        end
    end

    a_pend_no_underflow: assert property (
        @(posedge iw_clk) disable iff (iw_rst) wb_we |-> pend[wb_rd] != '0
    ) else $error("decode_stage: register write with no pending writer");

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input logic           iw_clk,
    input logic           iw_rst,
    input logic           freeze,
    pipe_link_if.consumer de,
    pipe_link_if.producer em
);
    import diad_pkg::*;

    opcode_t            op;
    logic [DATA_W-1:0]  sum;
    logic [DADDR_W-1:0] daddr;
    logic [DATA_W-1:0]  alu;

    assign op    = de.instr.r.opcode;
    assign sum   = de.op_a + de.op_b;
    assign daddr = sum[DADDR_W-1:0];

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI: alu = sum;
            OP_SUB:          alu = de.op_a - de.op_b;
            OP_AND:          alu = de.op_a & de.op_b;
            OP_OR:           alu = de.op_a | de.op_b;
            OP_XOR:          alu = de.op_a ^ de.op_b;
            OP_LD, OP_ST:    alu = DATA_W'(daddr);
            default:         alu = '0;
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            em.valid <= 1'b0;
        end else if (!freeze) begin
            em.valid <= de.valid;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (!freeze) begin
            em.pc     <= de.pc;
            em.instr  <= de.instr;
            em.op_a   <= (op == OP_ST) ? de.result : de.op_a;  // Store data moves to op_a.
            em.op_b   <= de.op_b;
            em.result <= alu;
        end
    end

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ns

module memory_stage (
    input logic           iw_clk,
    input logic           iw_rst,
    input logic           freeze,
    pipe_link_if.consumer em,
    pipe_link_if.producer mw
);
    import diad_pkg::*;

    logic [DATA_W-1:0]  dmem [DMEM_N];
    opcode_t            op;
    logic [DADDR_W-1:0] daddr;

    assign op    = em.instr.r.opcode;
    assign daddr = em.result[DADDR_W-1:0];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < DMEM_N; i++) begin
                dmem[i] <= '0;
            end
        end else if (!freeze && em.valid && op == OP_ST) begin
            dmem[daddr] <= em.op_a;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            mw.valid <= 1'b0;
        end else if (!freeze) begin
            mw.valid <= em.valid;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (!freeze) begin
            mw.pc     <= em.pc;
            mw.instr  <= em.instr;
            mw.op_a   <= em.op_a;
            mw.op_b   <= em.op_b;
            mw.result <= (op == OP_LD) ? dmem[daddr] :
                         (op == OP_ST) ? em.op_a : em.result;
        end
    end

endmodule

//--- hdl/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage (
    input logic                          iw_clk,
    input logic                          iw_rst,
    pipe_link_if.consumer                mw,
    input logic                          trace_credit,
    output logic                         wb_we,
    output logic [diad_pkg::REG_W-1:0]   wb_rd,
    output logic [diad_pkg::DATA_W-1:0]  wb_data,
    output logic                         freeze,
    output logic                         trace_valid,
    output logic [diad_pkg::IADDR_W-1:0] trace_pc,
    output diad_pkg::opcode_t            trace_op,
    output logic [diad_pkg::REG_W-1:0]   trace_rd,
    output logic [diad_pkg::DATA_W-1:0]  trace_data,
    output logic                         halted
);
    import diad_pkg::*;

    logic [CREDIT_W-1:0] credits;
    opcode_t             op;
    logic                send;

    assign op      = mw.instr.r.opcode;
    assign send    = mw.valid && credits != '0;
    assign freeze  = mw.valid && credits == '0;  // Hold the slot until a credit returns.
    assign wb_we   = send && writes_rd(op);
    assign wb_rd   = mw.instr.r.rd;
    assign wb_data = mw.result;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            credits     <= CREDIT_W'(TRACE_CREDITS);
            trace_valid <= 1'b0;
            halted      <= 1'b0;
        end else begin
            credits     <= credits - CREDIT_W'(send) + CREDIT_W'(trace_credit);
            trace_valid <= send;
            if (trace_valid && trace_op == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        if (send) begin
            trace_pc   <= mw.pc;
            trace_op   <= op;
            trace_rd   <= mw.instr.r.rd;
            trace_data <= (writes_rd(op) || op == OP_ST) ? mw.result : '0;
        end
    end

    a_credit_bound: assert property (
        @(posedge iw_clk) disable iff (iw_rst) credits <= CREDIT_W'(TRACE_CREDITS)
    ) else $error("writeback_stage: more credits returned than sent");

endmodule

//--- hdl/diad_core.sv
`timescale 1ns/1ns

module diad_core (
    input logic                          iw_clk,
    input logic                          iw_rst,
    input logic                          run,
    input logic                          load_en,
    input logic [diad_pkg::IADDR_W-1:0]  load_addr,
    input diad_pkg::instr_t              load_data,
    input logic                          trace_credit,
    output logic                         trace_valid,
    output logic [diad_pkg::IADDR_W-1:0] trace_pc,
    output diad_pkg::opcode_t            trace_op,
    output logic [diad_pkg::REG_W-1:0]   trace_rd,
    output logic [diad_pkg::DATA_W-1:0]  trace_data,
    output logic                         halted
);
    import diad_pkg::*;

    logic              freeze;
    logic              hold_fetch;
    logic              wb_we;
    logic [REG_W-1:0]  wb_rd;
    logic [DATA_W-1:0] wb_data;

    pipe_link_if fd ();
    pipe_link_if de ();
    pipe_link_if em ();
    pipe_link_if mw ();

    fetch_stage u_fetch (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .run        (run),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .freeze     (freeze),
        .hold_fetch (hold_fetch),
        .fd         (fd.producer)
    );

    decode_stage u_decode (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .freeze     (freeze),
        .fd         (fd.consumer),
        .de         (de.producer),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .hold_fetch (hold_fetch)
    );

    execute_stage u_execute (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .freeze (freeze),
        .de     (de.consumer),
        .em     (em.producer)
    );

    memory_stage u_memory (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .freeze (freeze),
        .em     (em.consumer),
        .mw     (mw.producer)
    );

    writeback_stage u_writeback (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .mw           (mw.consumer),
        .trace_credit (trace_credit),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .freeze       (freeze),
        .trace_valid  (trace_valid),
        .trace_pc     (trace_pc),
        .trace_op     (trace_op),
        .trace_rd     (trace_rd),
        .trace_data   (trace_data),
        .halted       (halted)
    );

endmodule

//--- bench/diad_tb.sv
`timescale 1ns/1ns

module diad_tb;
    import diad_pkg::*;

    typedef struct packed {
        logic [IADDR_W-1:0] pc;
        logic [3:0]         op;
        logic [REG_W-1:0]   rd;
        logic [DATA_W-1:0]  data;
    } record_t;

    logic               iw_clk;
    logic               iw_rst;
    logic               run;
    logic               load_en;
    logic [IADDR_W-1:0] load_addr;
    instr_t             load_data;
    logic               trace_credit;
    logic               trace_valid;
    logic [IADDR_W-1:0] trace_pc;
    opcode_t            trace_op;
    logic [REG_W-1:0]   trace_rd;
    logic [DATA_W-1:0]  trace_data;
    logic               halted;

    logic [31:0]        lfsr_state;
    logic [DATA_W-1:0]  prog [IMEM_N];
    int                 prog_len;
    record_t            exp_q [$];
    int                 value_errors;
    int                 other_errors;
    int                 timeouts;

    diad_core i_diad_core (.*);

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [REG_W-1:0] pick_reg(input logic dense);
        logic [31:0] v;
        if (dense) begin
            v = take_bits(2);
            return (v == 32'd3) ? REG_W'(1) : REG_W'(v);  // Only r0 to r2.
        end
        return REG_W'(take_bits(3));
    endfunction

    task automatic check_value(input string name, input int pc, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("ERR %s (pc %0d): got 0x%0h, expected 0x%0h", name, pc, got, want);
            value_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            other_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge iw_clk);
        #1;
    endtask

    task automatic apply_reset();
        iw_rst       = 1'b1;
        run          = 1'b0;
        load_en      = 1'b0;
        trace_credit = 1'b0;
        repeat (10) next_cycle();
        iw_rst = 1'b0;
        next_cycle();
        check_true(!trace_valid && !halted, "trace_valid or halted is high after reset");
    endtask

    task automatic gen_program(input logic dense);
        logic [3:0]       op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [5:0]       low;
        int               n;
        n = 15 + int'(take_bits(4));
        for (int k = 0; k < n; k++) begin
            op  = 4'(take_bits(3)) + 4'd1;
            rd  = pick_reg(dense);
            rs1 = pick_reg(dense);
            if (op == 4'(OP_ADDI) || op == 4'(OP_LD) || op == 4'(OP_ST)) begin
                low = 6'(take_bits(6));  // Signed immediate.
            end else begin
                low = {pick_reg(dense), 3'(take_bits(3))};
            end
            prog[k] = {op, rd, rs1, low};
        end
        // The last two slots store a word and load it back from the same address.
        prog[n-2][15:12] = 4'(OP_ST);
        prog[n-1]        = {4'(OP_LD), prog[n-1][11:9], prog[n-2][8:0]};
        prog[n]  = {4'(OP_HALT), 12'(take_bits(12))};
        prog_len = n + 1;
    endtask

    // Runs the program in order and queues the record each instruction should retire.
    task automatic build_expected();
        logic [DATA_W-1:0]  mregs [REG_N];
        logic [DATA_W-1:0]  mmem [DMEM_N];
        logic [3:0]         op;
        logic [REG_W-1:0]   rd;
        logic [DATA_W-1:0]  a;
        logic [DATA_W-1:0]  b;
        logic [DATA_W-1:0]  imm;
        logic [DATA_W-1:0]  val;
        logic [DADDR_W-1:0] addr;
        logic               wr;
        record_t            rec;
        for (int i = 0; i < DMEM_N; i++) begin
            mmem[i] = '0;
        end
        for (int i = 0; i < REG_N; i++) begin
            mregs[i] = '0;
        end
        exp_q.delete();
        for (int p = 0; p < prog_len; p++) begin
            op   = prog[p][15:12];
            rd   = prog[p][11:9];
            a    = mregs[prog[p][8:6]];
            b    = mregs[prog[p][5:3]];
            imm  = {{(DATA_W - 6){prog[p][5]}}, prog[p][5:0]};
            addr = 4'(a + imm);
            val  = '0;
            wr   = 1'b1;
            case (op)
                OP_ADD:  val = a + b;
                OP_SUB:  val = a - b;
                OP_AND:  val = a & b;
                OP_OR:   val = a | b;
                OP_XOR:  val = a ^ b;
                OP_ADDI: val = a + imm;
                OP_LD:   val = mmem[addr];
                OP_ST: begin
                    val        = mregs[rd];
                    mmem[addr] = val;
                    wr         = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                mregs[rd] = val;
            end
            rec = {IADDR_W'(p), op, rd, val};
            exp_q.push_back(rec);
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < prog_len; a++) begin
            load_en   = 1'b1;
            load_addr = IADDR_W'(a);
            load_data = prog[a];
            next_cycle();
            check_true(!trace_valid && !halted, "trace output active while loading");
        end
        load_en = 1'b0;
    endtask

    task automatic run_program(input int id);
        record_t want;
        int      outstanding;
        int      pause;
        int      cycles;
        int      halt_cycle;
        outstanding = 0;
        pause       = 0;
        cycles      = 0;
        halt_cycle  = -1;
        run         = 1'b1;
        while (cycles < 3000 && (halt_cycle < 0 || cycles < halt_cycle + 32)) begin
            next_cycle();
            cycles++;
            trace_credit = 1'b0;
            if (halt_cycle < 0) begin
                check_true(!halted, "halted rose before the HALT record");
            end else begin
                check_true(halted, "halted is low after the HALT record");
            end
            if (trace_valid) begin
                outstanding++;
                check_true(outstanding <= TRACE_CREDITS, "more records in flight than credits");
                if (halt_cycle >= 0 || exp_q.size() == 0) begin
                    check_true(1'b0, $sformatf("Extra trace record at pc %0d", trace_pc));
                end else begin
                    want = exp_q.pop_front();
                    check_value("trace_pc", want.pc, 32'(trace_pc), 32'(want.pc));
                    check_value("trace_op", want.pc, 32'(trace_op), 32'(want.op));
                    check_value("trace_rd", want.pc, 32'(trace_rd), 32'(want.rd));
                    check_value("trace_data", want.pc, 32'(trace_data), 32'(want.data));
                    if (want.op == 4'(OP_HALT)) begin
                        halt_cycle = cycles;
                    end
                end
            end
            if (pause > 0) begin
                pause--;
            end else if (outstanding > 0) begin
                if (take_bits(5) == 32'd0) begin
                    pause = 16 + int'(take_bits(5));  // Long gap in credit return.
                end else if (take_bits(1) == 32'd1) begin
                    trace_credit = 1'b1;
                    outstanding--;
                end
            end
        end
        if (halt_cycle < 0) begin
            $display("Timeout: program %0d did not retire its HALT within 3000 cycles", id);
            timeouts++;
        end
        run = 1'b0;
    endtask

    initial begin
        lfsr_state   = 32'hd452;
        value_errors = 0;
        other_errors = 0;
        timeouts     = 0;
        iw_rst       = 1'b1;
        run          = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        trace_credit = 1'b0;
        for (int t = 0; t < 3; t++) begin
            apply_reset();
            gen_program(t != 0);  // Later programs crowd onto r0 to r2.
            build_expected();
            load_program();
            run_program(t);
        end
        $display("value errors: %0d, other failures: %0d, timeouts: %0d",
                 value_errors, other_errors, timeouts);
        if (value_errors + other_errors + timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/diad_pkg.sv
hdl/pipe_link_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/writeback_stage.sv
hdl/diad_core.sv
bench/diad_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the diad testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module diad_tb -f list.f -o diad_sim

./obj_dir/diad_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
